// File: src/wing_pkg.sv
package wing_pkg;

  // ----------------------------------------
  // widths
  // ----------------------------------------
  localparam int wing_width        = 16;  // wing pins
  localparam int pwm_width_default = 16;
  localparam int slv_dwidth        = 32;  // bus data
  localparam int num_reg           = 32;  // chip enable slots

  // ----------------------------------------
  // register slots
  // ----------------------------------------
  // slot k is selected by chip enable bit num_reg-1-k

  localparam int reg_port       = 0;
  localparam int reg_port_set   = 1;
  localparam int reg_port_clr   = 2;
  localparam int reg_port_tgl   = 3;

  localparam int reg_dir        = 4;
  localparam int reg_dir_set    = 5;
  localparam int reg_dir_clr    = 6;

  localparam int reg_pin        = 7;   // write toggles port

  localparam int reg_pwm_cmp0   = 8;   // channels 0..15 in slots 8..23

  localparam int reg_pwm_en     = 24;
  localparam int reg_pwm_en_set = 25;
  localparam int reg_pwm_en_clr = 26;

  localparam int reg_int_sel    = 27;  // rise even bit, fall odd bit
  localparam int reg_int_flag   = 28;  // write one to clear
  localparam int reg_led_map    = 29;

  // led n shows pin 12+n
  localparam logic [15:0] led_map_reset = 16'hfedc;

  // ----------------------------------------
  // types
  // ----------------------------------------

  typedef struct packed {
    logic [3:0] led4;
    logic [3:0] led3;
    logic [3:0] led2;
    logic [3:0] led1;  // low nibble
  } led_sel_t;

  // register word on the bus side, pin selects on the led side
  typedef union packed {
    logic [15:0] word;
    led_sel_t    sel;
  } led_map_u;

  typedef struct packed {
    logic [slv_dwidth-1:0]   data;
    logic [slv_dwidth/8-1:0] be;
    logic [num_reg-1:0]      rd_ce;
    logic [num_reg-1:0]      wr_ce;
  } bus_req_t;

endpackage

// File: src/wing_regs.sv
`timescale 1ns/1ns

module wing_regs #(
  parameter int pwm_width = wing_pkg::pwm_width_default
) (
  input  logic                                           Bus2IP_Clk,
  input  logic                                           rst,
  input  wing_pkg::bus_req_t                             bus,
  input  logic [wing_pkg::wing_width-1:0]                pins_sync,
  input  logic [wing_pkg::wing_width-1:0]                int_flag,
  output logic [wing_pkg::wing_width-1:0]                port,
  output logic [wing_pkg::wing_width-1:0]                dir,
  output logic [wing_pkg::wing_width-1:0]                pwm_en,
  output logic [wing_pkg::wing_width-1:0][pwm_width-1:0] pwm_cmp,
  output logic [2*wing_pkg::wing_width-1:0]              int_sel,
  output wing_pkg::led_map_u                             led_map,
  output logic [wing_pkg::wing_width-1:0]                flag_clr,
  output logic [wing_pkg::slv_dwidth-1:0]                rd_data,
  output logic                                           rd_ack,
  output logic                                           wr_ack
);

  localparam int ww     = wing_pkg::wing_width;
  localparam int dw     = wing_pkg::slv_dwidth;
  localparam int nreg   = wing_pkg::num_reg;
  localparam int slot_w = $clog2(nreg);

  logic [dw-1:0]     be_mask;   // byte enables spread to bits
  logic [dw-1:0]     wbits;     // written ones inside enabled bytes
  logic              wr_valid;
  logic              rd_valid;
  logic [slot_w-1:0] wr_slot;
  logic [slot_w-1:0] rd_slot;

  // chip enable bit num_reg-1-k selects slot k
  function automatic logic [slot_w-1:0] ce_slot(input logic [nreg-1:0] ce);
    logic [slot_w-1:0] slot;
    slot = '0;
    for (int k = 0; k < nreg; k++)
    begin
      if (ce[nreg-1-k])
        slot = slot_w'(k);
    end
    return slot;
  endfunction

  // ----------------------------------------
  // decode
  // ----------------------------------------

  always_comb
  begin
    for (int i = 0; i < dw; i++)
      be_mask[i] = bus.be[i/8];
  end

  assign wbits    = bus.data & be_mask;

  assign wr_valid = $onehot(bus.wr_ce);  // anything else writes nothing
  assign rd_valid = $onehot(bus.rd_ce);
  assign wr_slot  = ce_slot(bus.wr_ce);
  assign rd_slot  = ce_slot(bus.rd_ce);

  assign wr_ack   = |bus.wr_ce;
  assign rd_ack   = |bus.rd_ce;

  // one cycle clear mask for the sticky flags
  assign flag_clr = (wr_valid && wr_slot == wing_pkg::reg_int_flag) ? wbits[ww-1:0] : '0;

  // ----------------------------------------
  // control registers
  // ----------------------------------------

  always_ff @(posedge Bus2IP_Clk)
  begin
    if (rst)
    begin
      port         <= '0;
      dir          <= '0;
      pwm_en       <= '0;
      int_sel      <= '0;
      led_map.word <= wing_pkg::led_map_reset;
    end
    else if (wr_valid)
    begin
      case (wr_slot)
        wing_pkg::reg_port:
          port <= (port & ~be_mask[ww-1:0]) | wbits[ww-1:0];
        wing_pkg::reg_port_set:
          port <= port | wbits[ww-1:0];
        wing_pkg::reg_port_clr:
          port <= port & ~wbits[ww-1:0];
        wing_pkg::reg_port_tgl,
        wing_pkg::reg_pin:
          port <= port ^ wbits[ww-1:0];  // pin slot toggles too
        wing_pkg::reg_dir:
          dir <= (dir & ~be_mask[ww-1:0]) | wbits[ww-1:0];
        wing_pkg::reg_dir_set:
          dir <= dir | wbits[ww-1:0];
        wing_pkg::reg_dir_clr:
          dir <= dir & ~wbits[ww-1:0];
        wing_pkg::reg_pwm_en:
          pwm_en <= (pwm_en & ~be_mask[ww-1:0]) | wbits[ww-1:0];
        wing_pkg::reg_pwm_en_set:
          pwm_en <= pwm_en | wbits[ww-1:0];
        wing_pkg::reg_pwm_en_clr:
          pwm_en <= pwm_en & ~wbits[ww-1:0];
        wing_pkg::reg_int_sel:
          int_sel <= (int_sel & ~be_mask[2*ww-1:0]) | wbits[2*ww-1:0];
        wing_pkg::reg_led_map:
          led_map.word <= (led_map.word & ~be_mask[15:0]) | wbits[15:0];
        default:
          ;
      endcase
    end
  end

  // compare values, one slot per channel
  always_ff @(posedge Bus2IP_Clk)
  begin
    if (wr_valid)
    begin
      for (int ch = 0; ch < ww; ch++)
      begin
        if (wr_slot == wing_pkg::reg_pwm_cmp0 + ch)
          pwm_cmp[ch] <= (pwm_cmp[ch] & ~be_mask[pwm_width-1:0]) | wbits[pwm_width-1:0];
      end
    end
  end

  // ----------------------------------------
  // read mux
  // ----------------------------------------

  always_comb
  begin
    rd_data = '0;
    if (rd_valid)
    begin
      case (rd_slot)
        wing_pkg::reg_port:     rd_data[ww-1:0]   = port;
        wing_pkg::reg_dir:      rd_data[ww-1:0]   = dir;
        wing_pkg::reg_pin:      rd_data[ww-1:0]   = pins_sync;
        wing_pkg::reg_pwm_en:   rd_data[ww-1:0]   = pwm_en;
        wing_pkg::reg_int_sel:  rd_data[2*ww-1:0] = int_sel;
        wing_pkg::reg_int_flag: rd_data[ww-1:0]   = int_flag;
        wing_pkg::reg_led_map:  rd_data[15:0]     = led_map.word;
        default:
        begin
          // set/clr/tgl forms and spare slots fall through as zero
          for (int ch = 0; ch < ww; ch++)
          begin
            if (rd_slot == wing_pkg::reg_pwm_cmp0 + ch)
              rd_data[pwm_width-1:0] = pwm_cmp[ch];
          end
        end
      endcase
    end
  end

endmodule

// File: src/wing_pin_input.sv
`timescale 1ns/1ns

module wing_pin_input (
  input  logic                               Bus2IP_Clk,
  input  logic                               rst,
  input  logic [wing_pkg::wing_width-1:0]    wing_in,
  input  logic [2*wing_pkg::wing_width-1:0]  int_sel,
  input  wing_pkg::led_map_u                 led_map,
  input  logic [wing_pkg::wing_width-1:0]    flag_clr,
  output logic [wing_pkg::wing_width-1:0]    pins_sync,
  output logic [wing_pkg::wing_width-1:0]    int_flag,
  output logic                               wing_int,
  output logic [3:0]                         wing_led
);

  localparam int ww = wing_pkg::wing_width;

  logic [ww-1:0] pins_d2;   // second stage
  logic [ww-1:0] edge_hit;  // selected edges this cycle

  // ----------------------------------------
  // synchronizer
  // ----------------------------------------

  always_ff @(posedge Bus2IP_Clk)
  begin
    if (rst)
    begin
      pins_sync <= '0;
      pins_d2   <= '0;
    end
    else
    begin
      pins_sync <= wing_in;
      pins_d2   <= pins_sync;
    end
  end

  // ----------------------------------------
  // edge detect and flags
  // ----------------------------------------

  always_comb
  begin
    for (int i = 0; i < ww; i++)
    begin
      edge_hit[i] = (~pins_d2[i] &  pins_sync[i] & int_sel[2*i])     // rising
                  | ( pins_d2[i] & ~pins_sync[i] & int_sel[2*i+1]);  // falling
    end
  end

  always_ff @(posedge Bus2IP_Clk)
  begin
    if (rst)
      int_flag <= '0;
    else
      int_flag <= (int_flag | edge_hit) & ~flag_clr;  // clear beats a new edge
  end

  assign wing_int = |int_flag;

  // ----------------------------------------
  // leds
  // ----------------------------------------

  assign wing_led[0] = pins_sync[led_map.sel.led1];
  assign wing_led[1] = pins_sync[led_map.sel.led2];
  assign wing_led[2] = pins_sync[led_map.sel.led3];
  assign wing_led[3] = pins_sync[led_map.sel.led4];

endmodule

// File: src/wing_pwm.sv
`timescale 1ns/1ns

module wing_pwm #(
  parameter int pwm_width = wing_pkg::pwm_width_default
) (
  input  logic                                           Bus2IP_Clk,
  input  logic                                           rst,
  input  logic [wing_pkg::wing_width-1:0]                port,
  input  logic [wing_pkg::wing_width-1:0]                dir,
  input  logic [wing_pkg::wing_width-1:0]                pwm_en,
  input  logic [wing_pkg::wing_width-1:0][pwm_width-1:0] pwm_cmp,
  output logic [wing_pkg::wing_width-1:0]                wing_out,
  output logic [wing_pkg::wing_width-1:0]                wing_dir
);

  localparam int ww = wing_pkg::wing_width;

  logic [pwm_width-1:0] pwm_cnt;  // shared by all channels
  logic [ww-1:0]        pwm_out;

  // ----------------------------------------
  // counter
  // ----------------------------------------

  always_ff @(posedge Bus2IP_Clk)
  begin
    if (rst)
      pwm_cnt <= '0;
    else
      pwm_cnt <= pwm_cnt + 1'b1;  // wraps every 2^pwm_width
  end

  // ----------------------------------------
  // comparators
  // ----------------------------------------

  // high for cmp counts out of each period
  always_comb
  begin
    for (int ch = 0; ch < ww; ch++)
      pwm_out[ch] = pwm_cmp[ch] > pwm_cnt;
  end

  // ----------------------------------------
  // pin merge
  // ----------------------------------------

  assign wing_out = (port & ~pwm_en) | (pwm_out & pwm_en);

  // active low drive, pwm pins are always driven
  assign wing_dir = ~(dir | pwm_en);

endmodule

// File: src/wing_gpio_top.sv
`timescale 1ns/1ns

module wing_gpio_top #(
  parameter int pwm_width = wing_pkg::pwm_width_default
) (
  input  logic                              Bus2IP_Clk,
  input  logic                              rst,
  input  logic [wing_pkg::slv_dwidth-1:0]   Bus2IP_Data,
  input  logic [wing_pkg::slv_dwidth/8-1:0] Bus2IP_BE,
  input  logic [wing_pkg::num_reg-1:0]      Bus2IP_RdCE,
  input  logic [wing_pkg::num_reg-1:0]      Bus2IP_WrCE,
  input  logic [wing_pkg::wing_width-1:0]   wing_in,
  output logic [wing_pkg::slv_dwidth-1:0]   IP2Bus_Data,
  output logic                              IP2Bus_RdAck,
  output logic                              IP2Bus_WrAck,
  output logic [wing_pkg::wing_width-1:0]   wing_out,
  output logic [wing_pkg::wing_width-1:0]   wing_dir,
  output logic                              wing_int,
  output logic [3:0]                        wing_led
);

  wing_pkg::bus_req_t                             bus_req;
  logic [wing_pkg::wing_width-1:0]                port;
  logic [wing_pkg::wing_width-1:0]                dir;
  logic [wing_pkg::wing_width-1:0]                pwm_en;
  logic [wing_pkg::wing_width-1:0][pwm_width-1:0] pwm_cmp;
  logic [2*wing_pkg::wing_width-1:0]              int_sel;
  wing_pkg::led_map_u                             led_map;
  logic [wing_pkg::wing_width-1:0]                flag_clr;
  logic [wing_pkg::wing_width-1:0]                pins_sync;
  logic [wing_pkg::wing_width-1:0]                int_flag;

  // ----------------------------------------
  // bus request
  // ----------------------------------------

  assign bus_req.data  = Bus2IP_Data;
  assign bus_req.be    = Bus2IP_BE;
  assign bus_req.rd_ce = Bus2IP_RdCE;
  assign bus_req.wr_ce = Bus2IP_WrCE;

  wing_regs #(
    .pwm_width (pwm_width)
  ) u_regs (
    .Bus2IP_Clk (Bus2IP_Clk),
    .rst        (rst),
    .bus        (bus_req),
    .pins_sync  (pins_sync),
    .int_flag   (int_flag),
    .port       (port),
    .dir        (dir),
    .pwm_en     (pwm_en),
    .pwm_cmp    (pwm_cmp),
    .int_sel    (int_sel),
    .led_map    (led_map),
    .flag_clr   (flag_clr),
    .rd_data    (IP2Bus_Data),
    .rd_ack     (IP2Bus_RdAck),
    .wr_ack     (IP2Bus_WrAck)
  );

  wing_pin_input u_pin_input (
    .Bus2IP_Clk (Bus2IP_Clk),
    .rst        (rst),
    .wing_in    (wing_in),
    .int_sel    (int_sel),
    .led_map    (led_map),
    .flag_clr   (flag_clr),
    .pins_sync  (pins_sync),
    .int_flag   (int_flag),
    .wing_int   (wing_int),
    .wing_led   (wing_led)
  );

  wing_pwm #(
    .pwm_width (pwm_width)
  ) u_pwm (
    .Bus2IP_Clk (Bus2IP_Clk),
    .rst        (rst),
    .port       (port),
    .dir        (dir),
    .pwm_en     (pwm_en),
    .pwm_cmp    (pwm_cmp),
    .wing_out   (wing_out),
    .wing_dir   (wing_dir)
  );

endmodule

// File: tests/wing_clk_gen.sv
`timescale 1ns/1ns

module wing_clk_gen (
  output logic Bus2IP_Clk,
  output logic rst
);

  initial
  begin
    Bus2IP_Clk = 1'b0;
    rst        = 1'b1;
    repeat (2) @(posedge Bus2IP_Clk);
    @(negedge Bus2IP_Clk);
    rst = 1'b0;  // released on a falling edge
  end

  always #5 Bus2IP_Clk = ~Bus2IP_Clk;  // 10 ns period

endmodule

// File: tests/wing_tb_assert.sv
`timescale 1ns/1ns

module wing_tb_assert (
  input logic                            Bus2IP_Clk,
  input logic                            rst,
  input wing_pkg::bus_req_t              bus,
  input logic [wing_pkg::slv_dwidth-1:0] rd_data,
  input logic                            rd_ack,
  input logic                            wr_ack
);

  int fail_count = 0;

  rd_ack_or: assert property (@(posedge Bus2IP_Clk) disable iff (rst) rd_ack == |bus.rd_ce)
  else
  begin
    fail_count++;
    $error("rd_ack differs from the OR of the read chip enables");
  end

  wr_ack_or: assert property (@(posedge Bus2IP_Clk) disable iff (rst) wr_ack == |bus.wr_ce)
  else
  begin
    fail_count++;
    $error("wr_ack differs from the OR of the write chip enables");
  end

  // idle read bus returns zero
  rd_idle_zero: assert property (@(posedge Bus2IP_Clk) disable iff (rst)
                                 (bus.rd_ce == '0) |-> (rd_data == '0))
  else
  begin
    fail_count++;
    $error("rd_data is not zero while no read chip enable is active");
  end

endmodule

bind wing_regs wing_tb_assert u_assert (
  .Bus2IP_Clk (Bus2IP_Clk),
  .rst        (rst),
  .bus        (bus),
  .rd_data    (rd_data),
  .rd_ack     (rd_ack),
  .wr_ack     (wr_ack)
);

// File: tests/wing_tb.sv
`timescale 1ns/1ns

module wing_tb;

  localparam int nreg = wing_pkg::num_reg;
  localparam int ww   = wing_pkg::wing_width;

  logic                            Bus2IP_Clk;
  logic                            rst;
  logic [wing_pkg::slv_dwidth-1:0] bus_data;
  logic [3:0]                      bus_be;
  logic [nreg-1:0]                 rd_ce;
  logic [nreg-1:0]                 wr_ce;
  logic [ww-1:0]                   wing_in;
  logic [wing_pkg::slv_dwidth-1:0] rd_data;
  logic                            rd_ack;
  logic                            wr_ack;
  logic [ww-1:0]                   wing_out;
  logic [ww-1:0]                   wing_dir;
  logic                            wing_int;
  logic [3:0]                      wing_led;

  logic [ww-1:0] port_m;  // register model
  logic [ww-1:0] dir_m;
  logic [ww-1:0] pwm_en_m;
  int            errors   = 0;
  int            timeouts = 0;

  wing_clk_gen u_clk_gen (
    .Bus2IP_Clk (Bus2IP_Clk),
    .rst        (rst)
  );

  wing_gpio_top #(
    .pwm_width (8)
  ) dut (
    .Bus2IP_Clk   (Bus2IP_Clk),
    .rst          (rst),
    .Bus2IP_Data  (bus_data),
    .Bus2IP_BE    (bus_be),
    .Bus2IP_RdCE  (rd_ce),
    .Bus2IP_WrCE  (wr_ce),
    .wing_in      (wing_in),
    .IP2Bus_Data  (rd_data),
    .IP2Bus_RdAck (rd_ack),
    .IP2Bus_WrAck (wr_ack),
    .wing_out     (wing_out),
    .wing_dir     (wing_dir),
    .wing_int     (wing_int),
    .wing_led     (wing_led)
  );

  function automatic logic [nreg-1:0] slot_ce(input int slot);
    logic [nreg-1:0] one;
    one = 1;
    return one << (nreg - 1 - slot);  // slot 0 is the top bit
  endfunction

  task automatic check_value(input string name, input logic [31:0] exp_val,
                             input logic [31:0] got);
    assert (got === exp_val)
    else
    begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp_val, got);
    end
  endtask

  // only ones inside enabled bytes change
  task automatic update_model(input int slot, input logic [3:0] be, input logic [31:0] data);
    logic [15:0] mask;
    logic [15:0] bits;
    mask = {{8{be[1]}}, {8{be[0]}}};
    bits = data[15:0] & mask;
    case (slot)
      wing_pkg::reg_port:       port_m = (port_m & ~mask) | bits;
      wing_pkg::reg_port_set:   port_m = port_m | bits;
      wing_pkg::reg_port_clr:   port_m = port_m & ~bits;
      wing_pkg::reg_port_tgl,
      wing_pkg::reg_pin:        port_m = port_m ^ bits;
      wing_pkg::reg_dir:        dir_m = (dir_m & ~mask) | bits;
      wing_pkg::reg_dir_set:    dir_m = dir_m | bits;
      wing_pkg::reg_dir_clr:    dir_m = dir_m & ~bits;
      wing_pkg::reg_pwm_en:     pwm_en_m = (pwm_en_m & ~mask) | bits;
      wing_pkg::reg_pwm_en_set: pwm_en_m = pwm_en_m | bits;
      wing_pkg::reg_pwm_en_clr: pwm_en_m = pwm_en_m & ~bits;
      default: ;
    endcase
  endtask

  task automatic bus_write(input string name, input int slot, input logic [3:0] be,
                           input logic [31:0] data);
    logic [15:0] exp_out;
    logic [15:0] exp_dir;
    @(negedge Bus2IP_Clk);
    bus_data = data;
    bus_be   = be;
    wr_ce    = slot_ce(slot);
    #1;
    check_value({name, " wr_ack"}, 1, wr_ack);
    @(negedge Bus2IP_Clk);
    wr_ce = '0;
    update_model(slot, be, data);
    exp_out = port_m & ~pwm_en_m;
    exp_dir = ~(dir_m | pwm_en_m);  // active low drive
    #1;
    check_value({name, " wing_out"}, exp_out, wing_out & ~pwm_en_m);
    check_value({name, " wing_dir"}, exp_dir, wing_dir);
  endtask

  task automatic bus_read(input string name, input int slot, input logic [31:0] exp_val);
    @(negedge Bus2IP_Clk);
    rd_ce = slot_ce(slot);
    #1;
    check_value({name, " rd_ack"}, 1, rd_ack);
    check_value(name, exp_val, rd_data);
    @(negedge Bus2IP_Clk);
    rd_ce = '0;
  endtask

  task automatic drive_pins(input string name, input logic [31:0] data,
                            input logic [31:0] exp_val);
    @(negedge Bus2IP_Clk);
    wing_in = data[ww-1:0];
    @(negedge Bus2IP_Clk);
    check_value({name, " wing_led"}, exp_val, wing_led);
  endtask

  // one full period of the 8 bit counter
  task automatic count_pwm(input string name, input int ch, input logic [31:0] exp_val);
    int high;
    high = 0;
    for (int i = 0; i < 256; i++)
    begin
      @(negedge Bus2IP_Clk);
      high += wing_out[ch];
    end
    check_value(name, exp_val, high);
  endtask

  task automatic wait_irq(input string name, input logic level);
    int n;
    n = 0;
    while (wing_int !== level && n < 20)
    begin
      @(negedge Bus2IP_Clk);
      n++;
    end
    assert (wing_int === level)
    else
    begin
      timeouts++;
      $display("Timeout in %s: wing_int did not go to %0d within 20 cycles", name, level);
    end
  endtask

  initial
  begin
    int          fd;
    int          n;
    int          line_no;
    int          slot;
    string       line;
    string       op;
    string       name;
    logic [31:0] be;
    logic [31:0] data;
    logic [31:0] exp_val;
    bus_data = '0;
    bus_be   = '0;
    rd_ce    = '0;
    wr_ce    = '0;
    wing_in  = '0;
    port_m   = '0;
    dir_m    = '0;
    pwm_en_m = '0;
    line_no  = 0;
    n        = 0;
    while (rst !== 1'b0 && n < 10)
    begin
      @(negedge Bus2IP_Clk);
      n++;
    end
    assert (rst === 1'b0)
    else
    begin
      timeouts++;
      $display("Timeout: reset was never released");
    end
    check_value("reset wing_dir", 32'h0000ffff, wing_dir);
    check_value("reset wing_int", 0, wing_int);

    fd = $fopen("tests/wing_stimulus.txt", "r");
    if (fd == 0)
    begin
      errors++;
      $display("Could not open tests/wing_stimulus.txt");
    end
    else
    begin
      while ($fgets(line, fd) > 0)
      begin
        line_no++;
        if (line.len() > 1 && line.getc(0) != "#")
        begin
          n    = $sscanf(line, "%s %d %h %h %h", op, slot, be, data, exp_val);
          name = $sformatf("%s slot %0d (line %0d)", op, slot, line_no);
          if (n != 5)
          begin
            errors++;
            $display("Stimulus line %0d does not hold five fields", line_no);
          end
          else if (op == "write")
            bus_write(name, slot, be[3:0], data);
          else if (op == "read")
            bus_read(name, slot, exp_val);
          else if (op == "pins")
            drive_pins(name, data, exp_val);
          else if (op == "pwm")
            count_pwm(name, slot, exp_val);
          else if (op == "irq")
            wait_irq(name, exp_val[0]);
          else
          begin
            errors++;
            $display("Unknown operation %s on stimulus line %0d", op, line_no);
          end
        end
      end
      $fclose(fd);
    end

    $display("checks failed: %0d, timeouts: %0d, assertion failures: %0d",
             errors, timeouts, dut.u_regs.u_assert.fail_count);
    if (errors == 0 && timeouts == 0 && dut.u_regs.u_assert.fail_count == 0)
      $display("=== PASS ===");
    else
      $display("=== FAIL ===");
    $finish;
  end

endmodule

// File: tests/wing_stimulus.txt
# op slot(dec) be(hex) data(hex) expected(hex)
# pins: data drives wing_in, expected is wing_led; pwm: high count of pin; irq: wing_int level
read  0  f 00000000 00000000
read  4  f 00000000 00000000
read  24 f 00000000 00000000
read  28 f 00000000 00000000
read  29 f 00000000 0000fedc
write 0  f 0000a5a5 00000000
write 1  3 00000f00 00000000
write 2  1 0000ffff 00000000
write 3  2 0000ffff 00000000
write 7  3 00000001 00000000
write 0  1 0000003c 00000000
read  0  f 00000000 0000503c
write 5  3 0000f00f 00000000
write 6  3 0000300c 00000000
read  4  f 00000000 0000c003
write 11 3 00000040 00000000
write 25 3 00000008 00000000
read  24 f 00000000 00000008
pwm   3  0 00000000 00000040
write 26 3 00000008 00000000
pwm   3  0 00000000 00000100
write 27 f 00000001 00000000
pins  0  0 00000001 00000000
irq   0  0 00000000 00000001
read  28 f 00000000 00000001
write 28 1 00000001 00000000
irq   0  0 00000000 00000000
pins  0  0 00000000 00000000
read  28 f 00000000 00000000
write 29 3 00003210 00000000
pins  0  0 0000000a 0000000a
read  7  f 00000000 0000000a
write 29 1 00000057 00000000
pins  0  0 000000a0 00000003
read  30 f 00000000 00000000

// File: tb.f
src/wing_pkg.sv
src/wing_regs.sv
src/wing_pin_input.sv
src/wing_pwm.sv
src/wing_gpio_top.sv
tests/wing_clk_gen.sv
tests/wing_tb_assert.sv
tests/wing_tb.sv
